// ==== Bender.yml ====
package:
  name: av1_entropy_encoder

sources:
  - src/av1_ec_pkg.sv
  - src/ec_range_stage.sv
  - src/ec_low_stage.sv
  - src/arithmetic_encoder.sv
  - src/precarry_fifo.sv
  - src/carry_resolver.sv
  - src/av1_entropy_encoder.sv
  - target: test
    files:
      - test/ec_tb_clock.sv
      - test/ec_fifo_checker.sv
      - test/ec_tb.sv

// ==== av1_entropy_encoder.f ====
src/av1_ec_pkg.sv
src/ec_range_stage.sv
src/ec_low_stage.sv
src/arithmetic_encoder.sv
src/precarry_fifo.sv
src/carry_resolver.sv
src/av1_entropy_encoder.sv
test/ec_tb_clock.sv
test/ec_fifo_checker.sv
test/ec_tb.sv

// ==== src/arithmetic_encoder.sv ====
`timescale 1ns/100ps

module arithmetic_encoder (
  input  logic                    general_clk,
  input  logic                    reset,
  input  logic                    symbol_valid,
  input  logic                    is_bool,
  input  av1_ec_pkg::ec_operand_u operand,
  input  av1_ec_pkg::symbol_t     symbol,
  input  av1_ec_pkg::nsyms_t      nsyms,
  output logic [1:0]              push_count,
  output av1_ec_pkg::precarry_t   word_0,
  output av1_ec_pkg::precarry_t   word_1
);

  // Stage 2 results, straight out of the range stage
  logic             valid_s2;
  av1_ec_pkg::low_t low_add_s2;
  av1_ec_pkg::cnt_t shift_d_s2;

  // Registers between stage 2 and stage 3
  logic             valid_s23;
  av1_ec_pkg::low_t low_add_s23;
  av1_ec_pkg::cnt_t shift_d_s23;

  // ----------------------------------------------------------------------
  // Stages 1 and 2
  // ----------------------------------------------------------------------
  ec_range_stage i_ec_range_stage (
    .general_clk (general_clk),
    .reset       (reset),
    .in_valid    (symbol_valid),
    .is_bool     (is_bool),
    .operand     (operand),
    .symbol      (symbol),
    .nsyms       (nsyms),
    .out_valid   (valid_s2),
    .low_add     (low_add_s2),
    .shift_d     (shift_d_s2),
    .range_out   ()
  );

  // Valid chain
  always_ff @(posedge general_clk) begin
    if (reset) begin
      valid_s23 <= 1'b0;
    end else begin
      valid_s23 <= valid_s2;
    end
  end

  // Only a live symbol loads the stage 2/3 payload
  always_ff @(posedge general_clk) begin
    if (valid_s2) begin
      low_add_s23 <= low_add_s2;
      shift_d_s23 <= shift_d_s2;
    end
  end

  // ----------------------------------------------------------------------
  // Stage 3
  // ----------------------------------------------------------------------
  ec_low_stage i_ec_low_stage (
    .general_clk (general_clk),
    .reset       (reset),
    .in_valid    (valid_s23),
    .low_add     (low_add_s23),
    .shift_d     (shift_d_s23),
    .push_count  (push_count),
    .word_0      (word_0),
    .word_1      (word_1)
  );

endmodule

// ==== src/av1_ec_pkg.sv ====
package av1_ec_pkg;

  // ----------------------------------------------------------------------
  // Widths
  // ----------------------------------------------------------------------
  localparam int RANGE_WIDTH  = 16;
  localparam int LOW_WIDTH    = 24;
  localparam int CNT_WIDTH    = 5;
  localparam int SYMBOL_WIDTH = 4;

  // ----------------------------------------------------------------------
  // Coding constants
  // ----------------------------------------------------------------------
  localparam int EC_MIN_PROB = 4;
  localparam int PROB_SHIFT  = 6;
  localparam int RANGE_INIT  = 32768;
  localparam int CNT_INIT    = -9;

  // Default depth of the precarry buffer, overridden from the top level
  localparam int FIFO_DEPTH_DEFAULT = 8;

  typedef logic [RANGE_WIDTH-1:0]        range_t;
  typedef logic [LOW_WIDTH-1:0]          low_t;
  typedef logic signed [CNT_WIDTH-1:0]   cnt_t;
  typedef logic [SYMBOL_WIDTH-1:0]       symbol_t;
  typedef logic [SYMBOL_WIDTH:0]         nsyms_t;

  // Byte in bits 7..0, carry in bit 8
  typedef logic [15:0] precarry_t;
  typedef logic [7:0]  byte_t;

  // Operand word, read as a CDF pair or as a boolean probability and bit
  typedef union packed {
    struct packed {
      range_t fl;
      range_t fh;
    } cdf;
    struct packed {
      range_t                 prob;
      logic [RANGE_WIDTH-2:0] pad;
      logic                   bit_val;
    } boolean;
  } ec_operand_u;

endpackage

// ==== src/av1_entropy_encoder.sv ====
`timescale 1ns/100ps

module av1_entropy_encoder #(
  parameter int FIFO_DEPTH = av1_ec_pkg::FIFO_DEPTH_DEFAULT
) (
  input  logic                    general_clk,
  input  logic                    reset,
  input  logic                    symbol_valid,
  input  logic                    is_bool,
  input  av1_ec_pkg::ec_operand_u operand,
  input  av1_ec_pkg::symbol_t     symbol,
  input  av1_ec_pkg::nsyms_t      nsyms,
  input  logic                    flush,
  output logic                    byte_valid,
  output av1_ec_pkg::byte_t       byte_data,
  output logic                    flush_done,
  output logic                    overflow
);

  // Encoder to FIFO
  logic [1:0]            push_count;
  av1_ec_pkg::precarry_t word_0, word_1;

  // FIFO to resolver
  logic                  fifo_empty, pop;
  av1_ec_pkg::precarry_t head_word;

  arithmetic_encoder i_arithmetic_encoder (
    .general_clk  (general_clk),
    .reset        (reset),
    .symbol_valid (symbol_valid),
    .is_bool      (is_bool),
    .operand      (operand),
    .symbol       (symbol),
    .nsyms        (nsyms),
    .push_count   (push_count),
    .word_0       (word_0),
    .word_1       (word_1)
  );

  precarry_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_precarry_fifo (
    .general_clk (general_clk),
    .reset       (reset),
    .push_count  (push_count),
    .word_0      (word_0),
    .word_1      (word_1),
    .pop         (pop),
    .head_word   (head_word),
    .fifo_empty  (fifo_empty),
    .overflow    (overflow)
  );

  carry_resolver i_carry_resolver (
    .general_clk (general_clk),
    .reset       (reset),
    .fifo_empty  (fifo_empty),
    .head_word   (head_word),
    .flush       (flush),
    .pop         (pop),
    .byte_valid  (byte_valid),
    .byte_data   (byte_data),
    .flush_done  (flush_done)
  );

endmodule

// ==== src/carry_resolver.sv ====
`timescale 1ns/100ps

module carry_resolver (
  input  logic                  general_clk,
  input  logic                  reset,
  input  logic                  fifo_empty,
  input  av1_ec_pkg::precarry_t head_word,
  input  logic                  flush,
  output logic                  pop,
  output logic                  byte_valid,
  output av1_ec_pkg::byte_t     byte_data,
  output logic                  flush_done
);

  localparam int RUN_WIDTH = 16;

  localparam logic [1:0] S_IDLE = 2'd0;
  localparam logic [1:0] S_RUN  = 2'd1;
  localparam logic [1:0] S_DONE = 2'd2;

  logic [1:0]           state;
  av1_ec_pkg::byte_t    pending, run_fill, w_byte;
  logic                 pend_valid, flush_req, flushing, w_carry;
  logic [RUN_WIDTH-1:0] run_cnt;
  logic                 first_word, word_emit, ff_word, flush_start;

  // Head word is consumed only while no byte is being released
  assign pop     = (state == S_IDLE) && !fifo_empty;
  assign w_carry = head_word[8];
  assign w_byte  = head_word[7:0];

  always_comb begin
    first_word  = pop && !pend_valid;
    word_emit   = pop && pend_valid && (w_carry || w_byte != 8'hFF);
    ff_word     = pop && pend_valid && !w_carry && w_byte == 8'hFF;
    flush_start = (state == S_IDLE) && fifo_empty && flush_req;
  end

  // ----------------------------------------------------------------------
  // Byte path
  // ----------------------------------------------------------------------
  always_ff @(posedge general_clk) begin
    if (first_word || word_emit) begin
      pending <= w_byte;
    end
    if (word_emit) begin
      byte_data <= pending + av1_ec_pkg::byte_t'(w_carry);
      run_fill  <= w_carry ? 8'h00 : 8'hFF;
    end else if (flush_start) begin
      byte_data <= pending;
      run_fill  <= 8'hFF;
    end else if (state == S_RUN) begin
      byte_data <= run_fill;
    end
  end

  // ----------------------------------------------------------------------
  // Control FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge general_clk) begin
    if (reset) begin
      state      <= S_IDLE;
      pend_valid <= 1'b0;
      run_cnt    <= '0;
      flush_req  <= 1'b0;
      flushing   <= 1'b0;
      byte_valid <= 1'b0;
      flush_done <= 1'b0;
    end else begin
      byte_valid <= 1'b0;
      flush_done <= 1'b0;
      if (flush) begin
        flush_req <= 1'b1;
      end
      case (state)
        S_IDLE: begin
          if (first_word) begin
            pend_valid <= 1'b1;
          end else if (word_emit) begin
            byte_valid <= 1'b1;
            if (run_cnt != '0) begin
              state <= S_RUN;
            end
          end else if (ff_word) begin
            run_cnt <= run_cnt + 1'b1;
          end else if (flush_start) begin
            // Last pending byte, then the stored 0xFF run
            flushing   <= 1'b1;
            pend_valid <= 1'b0;
            byte_valid <= pend_valid;
            state      <= (pend_valid && run_cnt != '0) ? S_RUN : S_DONE;
          end
        end
        S_RUN: begin
          byte_valid <= 1'b1;
          run_cnt    <= run_cnt - 1'b1;
          if (run_cnt == RUN_WIDTH'(1)) begin
            state <= flushing ? S_DONE : S_IDLE;
          end
        end
        S_DONE: begin
          flush_done <= 1'b1;
          flushing   <= 1'b0;
          flush_req  <= 1'b0;
          state      <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// ==== src/ec_low_stage.sv ====
`timescale 1ns/100ps

module ec_low_stage (
  input  logic                  general_clk,
  input  logic                  reset,
  input  logic                  in_valid,
  input  av1_ec_pkg::low_t      low_add,
  input  av1_ec_pkg::cnt_t      shift_d,
  output logic [1:0]            push_count,
  output av1_ec_pkg::precarry_t word_0,
  output av1_ec_pkg::precarry_t word_1
);

  av1_ec_pkg::low_t      low_q, low_sum, low_next;
  av1_ec_pkg::low_t      mask_hi, mask_lo;
  av1_ec_pkg::cnt_t      cnt_q, cnt_next;
  logic signed [5:0]     s_val;
  logic [4:0]            sh_hi, sh_lo;
  logic [1:0]            push_next;
  av1_ec_pkg::precarry_t w0_next, w1_next;

  // ----------------------------------------------------------------------
  // Normalization
  // ----------------------------------------------------------------------
  always_comb begin
    low_sum = low_q + low_add;
    s_val   = cnt_q + shift_d;

    // Bit positions of the two output bytes, cnt+16 and cnt+8
    sh_hi   = 5'(cnt_q) + 5'd16;
    sh_lo   = sh_hi - 5'd8;
    mask_hi = (av1_ec_pkg::low_t'(1) << sh_hi) - av1_ec_pkg::low_t'(1);
    mask_lo = (av1_ec_pkg::low_t'(1) << sh_lo) - av1_ec_pkg::low_t'(1);

    // Upper word keeps the carry in bit 8
    w0_next = av1_ec_pkg::precarry_t'(low_sum >> sh_hi);
    w1_next = av1_ec_pkg::precarry_t'((low_sum & mask_hi) >> sh_lo);

    push_next = 2'd0;
    cnt_next  = av1_ec_pkg::cnt_t'(s_val);
    low_next  = low_sum << shift_d;
    if (!s_val[5]) begin
      if (s_val >= 6'sd8) begin
        push_next = 2'd2;
        cnt_next  = av1_ec_pkg::cnt_t'(s_val - 6'sd24);
        low_next  = (low_sum & mask_lo) << shift_d;
      end else begin
        push_next = 2'd1;
        cnt_next  = av1_ec_pkg::cnt_t'(s_val - 6'sd16);
        low_next  = (low_sum & mask_hi) << shift_d;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Stage 3 registers, low and cnt feedback
  // ----------------------------------------------------------------------
  always_ff @(posedge general_clk) begin
    if (reset) begin
      low_q      <= '0;
      cnt_q      <= av1_ec_pkg::cnt_t'(av1_ec_pkg::CNT_INIT);
      push_count <= 2'd0;
    end else begin
      push_count <= 2'd0;
      if (in_valid) begin
        low_q      <= low_next;
        cnt_q      <= cnt_next;
        push_count <= push_next;
      end
    end
  end

  always_ff @(posedge general_clk) begin
    if (in_valid) begin
      word_0 <= w0_next;
      word_1 <= w1_next;
    end
  end

endmodule

// ==== src/ec_range_stage.sv ====
`timescale 1ns/100ps

module ec_range_stage (
  input  logic                    general_clk,
  input  logic                    reset,
  input  logic                    in_valid,
  input  logic                    is_bool,
  input  av1_ec_pkg::ec_operand_u operand,
  input  av1_ec_pkg::symbol_t     symbol,
  input  av1_ec_pkg::nsyms_t      nsyms,
  output logic                    out_valid,
  output av1_ec_pkg::low_t        low_add,
  output av1_ec_pkg::cnt_t        shift_d,
  output av1_ec_pkg::range_t      range_out
);

  localparam int PW = av1_ec_pkg::RANGE_WIDTH - av1_ec_pkg::PROB_SHIFT;

  // Shifted probabilities and minimum-probability terms
  logic [PW-1:0]      fl_sh_c, fh_sh_c;
  logic               has_u_c;
  av1_ec_pkg::range_t n_minus_s, u_min_c, v_min_c;

  logic               s1_valid, s1_bool, s1_has_u;
  logic [PW-1:0]      s1_fl_sh, s1_fh_sh;
  av1_ec_pkg::range_t s1_u_min, s1_v_min;

  av1_ec_pkg::range_t range_q, u_val, v_val, r_new, low_gain;
  logic [PW+7:0]      prod_u, prod_v;
  av1_ec_pkg::cnt_t   d_c;

  // Leading zero count of a nonzero range
  function automatic av1_ec_pkg::cnt_t norm_shift(input av1_ec_pkg::range_t r);
    av1_ec_pkg::cnt_t d;
    d = '0;
    for (int i = 0; i < av1_ec_pkg::RANGE_WIDTH; i++) begin
      if (r[i]) begin
        d = av1_ec_pkg::cnt_t'(av1_ec_pkg::RANGE_WIDTH - 1 - i);
      end
    end
    return d;
  endfunction

  // ----------------------------------------------------------------------
  // Stage 1: operand decode
  // ----------------------------------------------------------------------
  always_comb begin
    n_minus_s = av1_ec_pkg::range_t'(nsyms) - av1_ec_pkg::range_t'(symbol) - 16'd1;
    if (is_bool) begin
      fl_sh_c = '0;
      fh_sh_c = PW'(operand.boolean.prob >> av1_ec_pkg::PROB_SHIFT);
      has_u_c = operand.boolean.bit_val;
      u_min_c = '0;
      v_min_c = av1_ec_pkg::range_t'(av1_ec_pkg::EC_MIN_PROB);
    end else begin
      fl_sh_c = PW'(operand.cdf.fl >> av1_ec_pkg::PROB_SHIFT);
      fh_sh_c = PW'(operand.cdf.fh >> av1_ec_pkg::PROB_SHIFT);
      // fl of 32768 marks the first symbol, no u term
      has_u_c = !operand.cdf.fl[av1_ec_pkg::RANGE_WIDTH-1];
      u_min_c = av1_ec_pkg::range_t'(av1_ec_pkg::EC_MIN_PROB * (n_minus_s + 16'd1));
      v_min_c = av1_ec_pkg::range_t'(av1_ec_pkg::EC_MIN_PROB * n_minus_s);
    end
  end

  always_ff @(posedge general_clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
    end
  end

  always_ff @(posedge general_clk) begin
    if (in_valid) begin
      s1_bool  <= is_bool;
      s1_has_u <= has_u_c;
      s1_fl_sh <= fl_sh_c;
      s1_fh_sh <= fh_sh_c;
      s1_u_min <= u_min_c;
      s1_v_min <= v_min_c;
    end
  end

  // ----------------------------------------------------------------------
  // Stage 2: range update and normalization shift
  // ----------------------------------------------------------------------
  always_comb begin
    prod_u   = range_q[av1_ec_pkg::RANGE_WIDTH-1 -: 8] * s1_fl_sh;
    prod_v   = range_q[av1_ec_pkg::RANGE_WIDTH-1 -: 8] * s1_fh_sh;
    u_val    = av1_ec_pkg::range_t'(prod_u >> 1) + s1_u_min;
    v_val    = av1_ec_pkg::range_t'(prod_v >> 1) + s1_v_min;
    low_gain = '0;
    r_new    = range_q - v_val;
    if (s1_bool) begin
      if (s1_has_u) begin
        low_gain = range_q - v_val;
        r_new    = v_val;
      end
    end else if (s1_has_u) begin
      low_gain = range_q - u_val;
      r_new    = u_val - v_val;
    end
    d_c = norm_shift(r_new);
  end

  // Range feedback closes here every cycle
  always_ff @(posedge general_clk) begin
    if (reset) begin
      range_q <= av1_ec_pkg::range_t'(av1_ec_pkg::RANGE_INIT);
    end else if (s1_valid) begin
      range_q <= r_new << d_c;
    end
  end

  assign out_valid = s1_valid;
  assign low_add   = av1_ec_pkg::low_t'(low_gain);
  assign shift_d   = d_c;
  assign range_out = range_q;

endmodule

// ==== src/precarry_fifo.sv ====
`timescale 1ns/100ps

module precarry_fifo #(
  parameter int FIFO_DEPTH = av1_ec_pkg::FIFO_DEPTH_DEFAULT
) (
  input  logic                  general_clk,
  input  logic                  reset,
  input  logic [1:0]            push_count,
  input  av1_ec_pkg::precarry_t word_0,
  input  av1_ec_pkg::precarry_t word_1,
  input  logic                  pop,
  output av1_ec_pkg::precarry_t head_word,
  output logic                  fifo_empty,
  output logic                  overflow
);

  localparam int AW = $clog2(FIFO_DEPTH);

  av1_ec_pkg::precarry_t mem [FIFO_DEPTH];
  logic [AW-1:0]         wr_ptr, wr_ptr_1, rd_ptr;
  logic [AW:0]           occupancy, space, push_amt;
  logic                  accept, do_pop;

  always_comb begin
    push_amt = (AW+1)'(push_count);
    space    = (AW+1)'(FIFO_DEPTH) - occupancy;
    // Whole push is dropped when both words do not fit
    accept   = push_amt <= space;
    do_pop   = pop && !fifo_empty;
    wr_ptr_1 = wr_ptr + 1'b1;
  end

  assign fifo_empty = occupancy == '0;
  assign head_word  = mem[rd_ptr];

  // word_0 lands first, word_1 right behind it
  always_ff @(posedge general_clk) begin
    if (accept && push_count != 2'd0) begin
      mem[wr_ptr] <= word_0;
    end
    if (accept && push_count == 2'd2) begin
      mem[wr_ptr_1] <= word_1;
    end
  end

  always_ff @(posedge general_clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      occupancy <= '0;
      overflow  <= 1'b0;
    end else begin
      if (accept) begin
        wr_ptr <= wr_ptr + AW'(push_count);
      end else begin
        overflow <= 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      occupancy <= occupancy + (accept ? push_amt : '0) - (AW+1)'(do_pop);
    end
  end

endmodule

// ==== test/ec_fifo_checker.sv ====
`timescale 1ns/100ps

module ec_fifo_checker #(
  parameter int FIFO_DEPTH = av1_ec_pkg::FIFO_DEPTH_DEFAULT
) (
  input logic                        general_clk,
  input logic                        reset,
  input logic                        pop,
  input logic                        fifo_empty,
  input logic [$clog2(FIFO_DEPTH):0] occupancy,
  input logic                        overflow
);

  // Number of failed assertions
  int unsigned fail_count = 0;

  // Resolver only consumes a word that is present
  pop_not_empty: assert property (
    @(posedge general_clk) disable iff (reset) pop |-> !fifo_empty
  ) else begin
    $error("FIFO popped while empty");
    fail_count++;
  end

  occupancy_bound: assert property (
    @(posedge general_clk) disable iff (reset) occupancy <= FIFO_DEPTH
  ) else begin
    $error("FIFO occupancy above its depth");
    fail_count++;
  end

  // Sticky flag cleared only by reset
  overflow_sticky: assert property (
    @(posedge general_clk) $fell(overflow) |-> $past(reset)
  ) else begin
    $error("FIFO overflow flag dropped without reset");
    fail_count++;
  end

endmodule

// ==== test/ec_tb.sv ====
`timescale 1ns/100ps

module ec_tb;

  localparam int BOOL_SYMBOLS    = 200;
  localparam int CDF_SYMBOLS     = 200;
  localparam int MIXED_SYMBOLS   = 200;
  localparam int CARRY_LIMIT     = 10000;
  localparam int TOTAL_SYMBOLS   = BOOL_SYMBOLS + CDF_SYMBOLS + MIXED_SYMBOLS + CARRY_LIMIT;
  localparam int WATCHDOG_CYCLES = 40 * TOTAL_SYMBOLS + 2000;
  localparam int FLUSH_LIMIT     = 2000;

  logic                    general_clk, reset;
  logic                    symbol_valid, is_bool, flush;
  av1_ec_pkg::ec_operand_u operand;
  av1_ec_pkg::symbol_t     symbol;
  av1_ec_pkg::nsyms_t      nsyms;
  logic                    byte_valid, flush_done, overflow;
  av1_ec_pkg::byte_t       byte_data;

  // Reference encoder and carry state
  int unsigned       ref_range, ref_low, ref_pending, ref_run;
  int                ref_cnt;
  bit                ref_pend_valid, carry_over_run;
  av1_ec_pkg::byte_t expected_q[$];

  int unsigned rng_state;
  int          error_count, check_count, byte_count, expected_count;
  string       test_name;

  ec_tb_clock i_ec_tb_clock (
    .general_clk (general_clk),
    .reset       (reset)
  );

  av1_entropy_encoder i_av1_entropy_encoder (
    .general_clk  (general_clk),
    .reset        (reset),
    .symbol_valid (symbol_valid),
    .is_bool      (is_bool),
    .operand      (operand),
    .symbol       (symbol),
    .nsyms        (nsyms),
    .flush        (flush),
    .byte_valid   (byte_valid),
    .byte_data    (byte_data),
    .flush_done   (flush_done),
    .overflow     (overflow)
  );

  bind precarry_fifo ec_fifo_checker #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_ec_fifo_checker (
    .general_clk (general_clk),
    .reset       (reset),
    .pop         (pop),
    .fifo_empty  (fifo_empty),
    .occupancy   (occupancy),
    .overflow    (overflow)
  );

  // ----------------------------------------------------------------------
  // Random numbers and compare tasks
  // ----------------------------------------------------------------------
  function automatic int unsigned xorshift32(input int unsigned x);
    int unsigned y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int unsigned next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic compare_byte(input av1_ec_pkg::byte_t expected, input av1_ec_pkg::byte_t actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("error in %s: byte expected %02h, actual %02h", test_name, expected, actual);
    end
  endtask

  task automatic compare_flag(input string what, input logic expected, input logic actual);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("error in %s: %s expected %b, actual %b", test_name, what, expected, actual);
    end
  endtask

  task automatic compare_count(input string what, input int expected, input int actual);
    check_count++;
    if (actual != expected) begin
      error_count++;
      $display("error in %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
    end
  endtask

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  function automatic int msb_index(input int unsigned value);
    int idx;
    idx = 0;
    for (int i = 0; i < 16; i++) begin
      if (value[i]) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  task automatic expect_byte(input av1_ec_pkg::byte_t b);
    expected_q.push_back(b);
    expected_count++;
  endtask

  // Carry rule for one precarry word
  task automatic resolve_word(input int unsigned w);
    int unsigned wb;
    wb = w & 32'hFF;
    if (!ref_pend_valid) begin
      ref_pending    = wb;
      ref_pend_valid = 1'b1;
    end else if (w[8]) begin
      if (ref_run != 0) begin
        carry_over_run = 1'b1;
      end
      expect_byte(av1_ec_pkg::byte_t'(ref_pending + 1));
      repeat (ref_run) expect_byte(8'h00);
      ref_pending = wb;
      ref_run     = 0;
    end else if (wb == 32'hFF) begin
      ref_run++;
    end else begin
      expect_byte(av1_ec_pkg::byte_t'(ref_pending));
      repeat (ref_run) expect_byte(8'hFF);
      ref_pending = wb;
      ref_run     = 0;
    end
  endtask

  task automatic drain_pending();
    if (ref_pend_valid) begin
      expect_byte(av1_ec_pkg::byte_t'(ref_pending));
    end
    repeat (ref_run) expect_byte(8'hFF);
    ref_pend_valid = 1'b0;
    ref_run        = 0;
  endtask

  task automatic encode_reference(input logic bool_sym, input av1_ec_pkg::ec_operand_u op,
                                  input av1_ec_pkg::symbol_t sym,
                                  input av1_ec_pkg::nsyms_t n);
    int unsigned r8, u, v, r_new, gain;
    int          n_minus_s, d, sv, c;
    r8   = ref_range >> 8;
    gain = 0;
    if (bool_sym) begin
      v = ((r8 * (op.boolean.prob >> 6)) >> 1) + 4;
      if (op.boolean.bit_val) begin
        gain  = ref_range - v;
        r_new = v;
      end else begin
        r_new = ref_range - v;
      end
    end else begin
      n_minus_s = int'(n) - 1 - int'(sym);
      v = ((r8 * (op.cdf.fh >> 6)) >> 1) + 4 * n_minus_s;
      if (op.cdf.fl < 32768) begin
        u     = ((r8 * (op.cdf.fl >> 6)) >> 1) + 4 * (n_minus_s + 1);
        gain  = ref_range - u;
        r_new = u - v;
      end else begin
        r_new = ref_range - v;
      end
    end
    // Normalization in libaom order
    d       = 15 - msb_index(r_new);
    ref_low = (ref_low + gain) & 32'hFF_FFFF;
    sv      = ref_cnt + d;
    if (sv >= 0) begin
      c = ref_cnt + 16;
      resolve_word((ref_low >> c) & 32'hFFFF);
      if (sv >= 8) begin
        resolve_word((ref_low & ((1 << c) - 1)) >> (c - 8));
        ref_low = ref_low & ((1 << (c - 8)) - 1);
        ref_cnt = sv - 24;
      end else begin
        ref_low = ref_low & ((1 << c) - 1);
        ref_cnt = sv - 16;
      end
    end else begin
      ref_cnt = sv;
    end
    ref_low   = (ref_low << d) & 32'hFF_FFFF;
    ref_range = (r_new << d) & 32'hFFFF;
  endtask

  // ----------------------------------------------------------------------
  // Drivers and monitor
  // ----------------------------------------------------------------------
  task automatic begin_test(input string name);
    test_name      = name;
    byte_count     = 0;
    expected_count = 0;
  endtask

  task automatic drive_symbol(input logic bool_sym, input av1_ec_pkg::ec_operand_u op,
                              input av1_ec_pkg::symbol_t sym, input av1_ec_pkg::nsyms_t n);
    @(negedge general_clk);
    symbol_valid = 1'b1;
    is_bool      = bool_sym;
    operand      = op;
    symbol       = sym;
    nsyms        = n;
    encode_reference(bool_sym, op, sym, n);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge general_clk);
      symbol_valid = 1'b0;
    end
  endtask

  // Pipeline drains in 3 cycles before the flush goes in
  task automatic run_flush();
    int waited;
    idle_cycles(4);
    drain_pending();
    @(negedge general_clk);
    flush = 1'b1;
    @(negedge general_clk);
    flush  = 1'b0;
    waited = 0;
    while (!flush_done && waited < FLUSH_LIMIT) begin
      @(negedge general_clk);
      waited++;
    end
    if (!flush_done) begin
      error_count++;
      $display("flush_done did not arrive within %0d cycles in %s", FLUSH_LIMIT, test_name);
    end
    compare_count("byte count", expected_count, byte_count);
  endtask

  always @(negedge general_clk) begin
    if (!reset && byte_valid) begin
      byte_count++;
      if (expected_q.size() == 0) begin
        error_count++;
        $display("Unexpected byte %02h in %s, the model has no byte left", byte_data, test_name);
      end else begin
        compare_byte(expected_q.pop_front(), byte_data);
      end
    end
  end

  // ----------------------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------------------
  task automatic reset_and_empty_flush();
    begin_test("reset_and_empty_flush");
    compare_flag("byte_valid", 1'b0, byte_valid);
    compare_flag("overflow", 1'b0, overflow);
    run_flush();
  endtask

  task automatic boolean_stream();
    av1_ec_pkg::ec_operand_u op;
    begin_test("boolean_stream");
    for (int i = 0; i < BOOL_SYMBOLS; i++) begin
      op                 = '0;
      op.boolean.prob    = av1_ec_pkg::range_t'(1 + next_rand() % 32767);
      op.boolean.bit_val = 1'(next_rand() & 1);
      drive_symbol(1'b1, op, '0, '0);
      idle_cycles(2 + next_rand() % 4);
    end
    run_flush();
    compare_flag("overflow", 1'b0, overflow);
  endtask

  task automatic cdf_stream();
    av1_ec_pkg::ec_operand_u op;
    int unsigned             n, s, fl;
    begin_test("cdf_stream");
    for (int i = 0; i < CDF_SYMBOLS; i++) begin
      n = 2 + next_rand() % 15;
      s = next_rand() % n;
      // Symbol 0 always starts at the top of the inverse CDF
      fl        = (s == 0) ? 32768 : 1 + next_rand() % 32767;
      op        = '0;
      op.cdf.fl = av1_ec_pkg::range_t'(fl);
      op.cdf.fh = av1_ec_pkg::range_t'(next_rand() % fl);
      drive_symbol(1'b0, op, av1_ec_pkg::symbol_t'(s), av1_ec_pkg::nsyms_t'(n));
      idle_cycles(2 + next_rand() % 4);
    end
    run_flush();
    compare_flag("overflow", 1'b0, overflow);
  endtask

  // Wide intervals keep the word rate low enough for the FIFO
  task automatic mixed_back_to_back();
    av1_ec_pkg::ec_operand_u op;
    int unsigned             s;
    begin_test("mixed_back_to_back");
    for (int i = 0; i < MIXED_SYMBOLS; i++) begin
      op = '0;
      if (next_rand() % 2 == 1) begin
        op.boolean.prob    = av1_ec_pkg::range_t'(8192 + next_rand() % 8192);
        op.boolean.bit_val = 1'(next_rand() & 1);
        drive_symbol(1'b1, op, '0, '0);
      end else begin
        s         = next_rand() % 4;
        op.cdf.fl = av1_ec_pkg::range_t'(32768 - 8192 * s);
        op.cdf.fh = av1_ec_pkg::range_t'(32768 - 8192 * (s + 1));
        drive_symbol(1'b0, op, av1_ec_pkg::symbol_t'(s), av1_ec_pkg::nsyms_t'(4));
      end
    end
    run_flush();
    compare_flag("overflow", 1'b0, overflow);
  endtask

  task automatic carry_propagation();
    av1_ec_pkg::ec_operand_u op;
    int                      sent;
    begin_test("carry_propagation");
    carry_over_run = 1'b0;
    sent           = 0;
    // Small probabilities give many bytes per symbol
    while (sent < CARRY_LIMIT && !carry_over_run) begin
      op                 = '0;
      op.boolean.prob    = av1_ec_pkg::range_t'(1 + next_rand() % 4095);
      op.boolean.bit_val = 1'(next_rand() & 1);
      drive_symbol(1'b1, op, '0, '0);
      idle_cycles(2 + next_rand() % 3);
      sent++;
    end
    run_flush();
    compare_flag("overflow", 1'b0, overflow);
    if (!carry_over_run) begin
      error_count++;
      $display("No carry across a 0xFF run occurred in %0d symbols", sent);
    end else begin
      $display("Carry across a 0xFF run reached after %0d symbols", sent);
    end
  endtask

  // ----------------------------------------------------------------------
  // Sequence and watchdog
  // ----------------------------------------------------------------------
  initial begin
    symbol_valid   = 1'b0;
    is_bool        = 1'b0;
    operand        = '0;
    symbol         = '0;
    nsyms          = '0;
    flush          = 1'b0;
    rng_state      = 92;
    ref_range      = av1_ec_pkg::RANGE_INIT;
    ref_low        = 0;
    ref_cnt        = av1_ec_pkg::CNT_INIT;
    ref_pending    = 0;
    ref_run        = 0;
    ref_pend_valid = 1'b0;
    carry_over_run = 1'b0;
    error_count    = 0;
    check_count    = 0;
    begin_test("startup");

    @(negedge general_clk);
    while (reset) begin
      @(negedge general_clk);
    end

    reset_and_empty_flush();
    boolean_stream();
    cdf_stream();
    mixed_back_to_back();
    carry_propagation();

    // Failed assertions of the bound FIFO checker
    error_count += i_av1_entropy_encoder.i_precarry_fifo.i_ec_fifo_checker.fail_count;

    $display("Checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge general_clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// ==== test/ec_tb_clock.sv ====
`timescale 1ns/100ps

module ec_tb_clock (
  output logic general_clk,
  output logic reset
);

  // 20 ns period
  initial begin
    general_clk = 1'b0;
    forever #10 general_clk = ~general_clk;
  end

  // Reset held for 5 rising edges, released on a falling edge
  initial begin
    reset = 1'b1;
    repeat (5) @(posedge general_clk);
    @(negedge general_clk);
    reset = 1'b0;
  end

endmodule
